// ==== codec_pkg.sv ====
// Codec package: pixel and channel widths, resolution modes, group limits, shifts and typedefs
package codec_pkg;

    // Stream and channel widths
    localparam int PIX_W   = 24;
    localparam int OUT_W   = 16;
    localparam int CHAN_W  = 8;
    localparam int SUM_W   = 12;
    localparam int CNT_W   = 4;
    localparam int SHIFT_W = 3;

    // Input user field layout
    localparam int USER_W        = 3;
    localparam int USER_LINE_BIT = 2;

    // Largest legal channel sum, 16 pixels at full scale
    localparam int SUM_MAX = 4080;

    typedef logic [PIX_W-1:0]   rgb888_t;
    typedef logic [OUT_W-1:0]   rgb565_t;
    typedef logic [CHAN_W-1:0]  chan_t;
    typedef logic [SUM_W-1:0]   chan_sum_t;
    typedef logic [CNT_W-1:0]   grp_cnt_t;
    typedef logic [SHIFT_W-1:0] shift_t;

    // Resolution mode as carried in s_user[1:0]
    typedef enum logic [1:0] {
        RES_FULL    = 2'd0,
        RES_HALF    = 2'd1,
        RES_QUARTER = 2'd2,
        RES_PASS    = 2'd3
    } res_mode_t;

    // Last index inside a group
    localparam grp_cnt_t GROUP_LAST_HALF    = 4'd3;
    localparam grp_cnt_t GROUP_LAST_QUARTER = 4'd15;

    // Divide by group size
    localparam shift_t SHIFT_HALF    = 3'd2;
    localparam shift_t SHIFT_QUARTER = 3'd4;

endpackage

// ==== pixel_decode.sv ====
// Decode stage: user field split, per-group mode capture, group position count and close detect
module pixel_decode (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  codec_pkg::rgb888_t               s_data,
    input  logic [codec_pkg::USER_W-1:0]     s_user,
    input  logic                             s_last,
    input  logic                             s_valid,
    input  logic                             advance,
    output logic                             dec_valid,
    output codec_pkg::rgb888_t               dec_pixel,
    output logic                             dec_first,
    output logic                             dec_close,
    output codec_pkg::shift_t                dec_shift,
    output logic                             dec_line_end,
    output logic                             dec_frame_end
);

    codec_pkg::grp_cnt_t  grp_cnt;
    codec_pkg::res_mode_t grp_mode;
    codec_pkg::res_mode_t cur_mode;
    codec_pkg::grp_cnt_t  last_idx;
    codec_pkg::shift_t    cur_shift;
    logic                 grp_start;
    logic                 grp_close;
    logic                 s_xfer;

    assign s_xfer    = s_valid && advance;
    assign grp_start = (grp_cnt == '0);

    // Mode comes from the first pixel of a group, then stays held
    assign cur_mode = grp_start ? codec_pkg::res_mode_t'(s_user[1:0]) : grp_mode;

    always_comb begin
        case (cur_mode)
            codec_pkg::RES_HALF: begin
                last_idx  = codec_pkg::GROUP_LAST_HALF;
                cur_shift = codec_pkg::SHIFT_HALF;
            end
            codec_pkg::RES_QUARTER: begin
                last_idx  = codec_pkg::GROUP_LAST_QUARTER;
                cur_shift = codec_pkg::SHIFT_QUARTER;
            end
            codec_pkg::RES_FULL, codec_pkg::RES_PASS: begin
                last_idx  = '0;
                cur_shift = '0;
            end
            default: begin
                last_idx  = '0;
                cur_shift = '0;
            end
        endcase
    end

    // Frame end cuts the group short
    assign grp_close = (grp_cnt == last_idx) || s_last;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            grp_cnt   <= '0;
            grp_mode  <= codec_pkg::RES_FULL;
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= s_valid;
            if (s_valid) begin
                if (grp_start) begin
                    grp_mode <= cur_mode;
                end
                grp_cnt <= grp_close ? '0 : grp_cnt + codec_pkg::grp_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (s_xfer) begin
            dec_pixel     <= s_data;
            dec_first     <= grp_start;
            dec_close     <= grp_close;
            dec_shift     <= cur_shift;
            dec_line_end  <= s_user[codec_pkg::USER_LINE_BIT];
            dec_frame_end <= s_last;
        end
    end

    // Later pixels of a group keep the shift of its first pixel
    assert property (@(posedge aclk) disable iff (!aresetn)
        (s_xfer && !grp_start) |-> (cur_shift == dec_shift));

endmodule

// ==== pixel_accumulate.sv ====
// Execute stage: per-channel group sums and shifted group average on close
module pixel_accumulate (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  advance,
    input  logic                  dec_valid,
    input  codec_pkg::rgb888_t    dec_pixel,
    input  logic                  dec_first,
    input  logic                  dec_close,
    input  codec_pkg::shift_t     dec_shift,
    input  logic                  dec_line_end,
    input  logic                  dec_frame_end,
    output logic                  avg_valid,
    output codec_pkg::chan_t      avg_r,
    output codec_pkg::chan_t      avg_g,
    output codec_pkg::chan_t      avg_b,
    output logic                  avg_line_end,
    output logic                  avg_frame_end
);

    codec_pkg::chan_t     pix_r;
    codec_pkg::chan_t     pix_g;
    codec_pkg::chan_t     pix_b;
    codec_pkg::chan_sum_t sum_r;
    codec_pkg::chan_sum_t sum_g;
    codec_pkg::chan_sum_t sum_b;
    codec_pkg::chan_sum_t base_r;
    codec_pkg::chan_sum_t base_g;
    codec_pkg::chan_sum_t base_b;
    codec_pkg::chan_sum_t next_r;
    codec_pkg::chan_sum_t next_g;
    codec_pkg::chan_sum_t next_b;
    logic                 dec_xfer;

    assign dec_xfer = dec_valid && advance;

    // Red sits in the top byte
    assign pix_r = dec_pixel[2*codec_pkg::CHAN_W +: codec_pkg::CHAN_W];
    assign pix_g = dec_pixel[codec_pkg::CHAN_W +: codec_pkg::CHAN_W];
    assign pix_b = dec_pixel[0 +: codec_pkg::CHAN_W];

    // First pixel restarts the sums
    assign base_r = dec_first ? '0 : sum_r;
    assign base_g = dec_first ? '0 : sum_g;
    assign base_b = dec_first ? '0 : sum_b;

    assign next_r = base_r + codec_pkg::chan_sum_t'(pix_r);
    assign next_g = base_g + codec_pkg::chan_sum_t'(pix_g);
    assign next_b = base_b + codec_pkg::chan_sum_t'(pix_b);

    always_ff @(posedge aclk) begin
        if (dec_xfer) begin
            sum_r <= next_r;
            sum_g <= next_g;
            sum_b <= next_b;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            avg_valid <= 1'b0;
        end else if (advance) begin
            // One beat per closed group
            avg_valid <= dec_valid && dec_close;
        end
    end

    // Nominal divide even on an early frame end close, no rounding
    always_ff @(posedge aclk) begin
        if (dec_xfer && dec_close) begin
            avg_r         <= codec_pkg::chan_t'(next_r >> dec_shift);
            avg_g         <= codec_pkg::chan_t'(next_g >> dec_shift);
            avg_b         <= codec_pkg::chan_t'(next_b >> dec_shift);
            avg_line_end  <= dec_line_end;
            avg_frame_end <= dec_frame_end;
        end
    end

    // Group sizes from decode keep every sum inside 16 x 255
    assert property (@(posedge aclk) disable iff (!aresetn)
        dec_xfer |->
            (({1'b0, base_r} + pix_r) <= codec_pkg::SUM_MAX) &&
            (({1'b0, base_g} + pix_g) <= codec_pkg::SUM_MAX) &&
            (({1'b0, base_b} + pix_b) <= codec_pkg::SUM_MAX));

endmodule

// ==== pixel_pack.sv ====
// Result stage: RGB565 packing, output register and pipeline advance generation
module pixel_pack (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                avg_valid,
    input  codec_pkg::chan_t    avg_r,
    input  codec_pkg::chan_t    avg_g,
    input  codec_pkg::chan_t    avg_b,
    input  logic                avg_line_end,
    input  logic                avg_frame_end,
    input  logic                m_ready,
    output logic                advance,
    output codec_pkg::rgb565_t  m_data,
    output logic                m_user,
    output logic                m_last,
    output logic                m_valid
);

    codec_pkg::rgb565_t packed_pix;

    // Register is free when empty or being drained this cycle
    assign advance = !m_valid || m_ready;

    // Keep the top 5, 6 and 5 bits
    assign packed_pix = {
        avg_r[codec_pkg::CHAN_W-1 -: 5],
        avg_g[codec_pkg::CHAN_W-1 -: 6],
        avg_b[codec_pkg::CHAN_W-1 -: 5]
    };

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_valid <= 1'b0;
        end else if (advance) begin
            m_valid <= avg_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance && avg_valid) begin
            m_data <= packed_pix;
            m_user <= avg_line_end;
            m_last <= avg_frame_end;
        end
    end

    // Pending average waits upstream while the output beat is stalled
    assert property (@(posedge aclk) disable iff (!aresetn)
        !advance |=>
            $stable(avg_valid) && $stable(avg_r) && $stable(avg_g) && $stable(avg_b) &&
            $stable(avg_line_end) && $stable(avg_frame_end));

endmodule

// ==== resolution_codec_top.sv ====
// Top level of the decimating codec: decode, accumulate and pack stages with stream ports
module resolution_codec_top (
    input  logic                          aclk,
    input  logic                          aresetn,
    // Input pixel stream
    input  codec_pkg::rgb888_t            s_data,
    input  logic [codec_pkg::USER_W-1:0]  s_user,
    input  logic                          s_last,
    input  logic                          s_valid,
    output logic                          s_ready,
    // Output pixel stream
    output codec_pkg::rgb565_t            m_data,
    output logic                          m_user,
    output logic                          m_last,
    output logic                          m_valid,
    input  logic                          m_ready
);

    logic               advance;
    logic               dec_valid;
    codec_pkg::rgb888_t dec_pixel;
    logic               dec_first;
    logic               dec_close;
    codec_pkg::shift_t  dec_shift;
    logic               dec_line_end;
    logic               dec_frame_end;
    logic               avg_valid;
    codec_pkg::chan_t   avg_r;
    codec_pkg::chan_t   avg_g;
    codec_pkg::chan_t   avg_b;
    logic               avg_line_end;
    logic               avg_frame_end;

    // Whole pipeline moves together
    assign s_ready = advance;

    pixel_decode decode_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_data        (s_data),
        .s_user        (s_user),
        .s_last        (s_last),
        .s_valid       (s_valid),
        .advance       (advance),
        .dec_valid     (dec_valid),
        .dec_pixel     (dec_pixel),
        .dec_first     (dec_first),
        .dec_close     (dec_close),
        .dec_shift     (dec_shift),
        .dec_line_end  (dec_line_end),
        .dec_frame_end (dec_frame_end)
    );

    pixel_accumulate accumulate_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .advance       (advance),
        .dec_valid     (dec_valid),
        .dec_pixel     (dec_pixel),
        .dec_first     (dec_first),
        .dec_close     (dec_close),
        .dec_shift     (dec_shift),
        .dec_line_end  (dec_line_end),
        .dec_frame_end (dec_frame_end),
        .avg_valid     (avg_valid),
        .avg_r         (avg_r),
        .avg_g         (avg_g),
        .avg_b         (avg_b),
        .avg_line_end  (avg_line_end),
        .avg_frame_end (avg_frame_end)
    );

    pixel_pack pack_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .avg_valid     (avg_valid),
        .avg_r         (avg_r),
        .avg_g         (avg_g),
        .avg_b         (avg_b),
        .avg_line_end  (avg_line_end),
        .avg_frame_end (avg_frame_end),
        .m_ready       (m_ready),
        .advance       (advance),
        .m_data        (m_data),
        .m_user        (m_user),
        .m_last        (m_last),
        .m_valid       (m_valid)
    );

endmodule

// ==== tb_resolution_codec.sv ====
// Testbench for the decimating codec: clock, reset, stimulus, queue model and checking assertions
module tb_resolution_codec;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 4000;

    logic                 aclk;
    logic                 aresetn;
    codec_pkg::rgb888_t   s_data;
    logic [2:0]           s_user;
    logic                 s_last;
    logic                 s_valid;
    logic                 s_ready;
    codec_pkg::rgb565_t   m_data;
    logic                 m_user;
    logic                 m_last;
    logic                 m_valid;
    logic                 m_ready = 1'b0;

    // Expected beats as {frame end, line end, rgb565}
    logic [17:0]          exp_q[$];
    logic                 exp_avail;
    codec_pkg::rgb565_t   exp_data;
    logic                 exp_user;
    logic                 exp_last;

    // Reference model state
    int                   mdl_cnt;
    int                   mdl_mode;
    int                   mdl_size;
    int                   mdl_shift;
    int                   sum_r;
    int                   sum_g;
    int                   sum_b;
    logic [7:0]           avg_r;
    logic [7:0]           avg_g;
    logic [7:0]           avg_b;

    logic                 bp_en;
    logic                 gap_en;

    resolution_codec_top dut_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_data  (s_data),
        .s_user  (s_user),
        .s_last  (s_last),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (m_data),
        .m_user  (m_user),
        .m_last  (m_last),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Offer one pixel and hold it until the DUT takes it
    task automatic send_pixel(input codec_pkg::rgb888_t data, input logic [1:0] mode,
                              input logic line_end, input logic frame_end);
        int waited;
        int gap;
        s_data  <= data;
        s_user  <= {line_end, mode};
        s_last  <= frame_end;
        s_valid <= 1'b1;
        waited = 0;
        @(posedge aclk);
        while (!s_ready && waited < ACCEPT_TIMEOUT) begin
            waited++;
            @(posedge aclk);
        end
        if (!s_ready) begin
            abort_run("input pixel was not accepted before the timeout");
        end
        if (gap_en) begin
            gap = $urandom % 3;
            if (gap != 0) begin
                s_valid <= 1'b0;
                repeat (gap) @(posedge aclk);
            end
        end
    endtask

    // Output side held off during reset, then a random stall pattern
    always @(posedge aclk) begin
        if (!aresetn) begin
            m_ready <= 1'b0;
        end else if (bp_en) begin
            m_ready <= ($urandom % 3) != 0;
        end else begin
            m_ready <= 1'b1;
        end
    end

    // Queue model of the averaging rules
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mdl_cnt   = 0;
            mdl_mode  = 0;
            exp_avail <= 1'b0;
        end else begin
            if (m_valid && m_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (s_valid && s_ready) begin
                if (mdl_cnt == 0) begin
                    mdl_mode = s_user[1:0];
                    sum_r    = 0;
                    sum_g    = 0;
                    sum_b    = 0;
                end
                sum_r += s_data[23:16];
                sum_g += s_data[15:8];
                sum_b += s_data[7:0];
                mdl_size  = (mdl_mode == 1) ? 4 : (mdl_mode == 2) ? 16 : 1;
                mdl_shift = (mdl_mode == 1) ? 2 : (mdl_mode == 2) ? 4 : 0;
                if (mdl_cnt + 1 == mdl_size || s_last) begin
                    // Nominal divide even when frame end cuts the group
                    avg_r = 8'(sum_r >> mdl_shift);
                    avg_g = 8'(sum_g >> mdl_shift);
                    avg_b = 8'(sum_b >> mdl_shift);
                    exp_q.push_back({s_last, s_user[2], avg_r[7:3], avg_g[7:2], avg_b[7:3]});
                    mdl_cnt = 0;
                end else begin
                    mdl_cnt++;
                end
            end
            if (exp_q.size() != 0) begin
                exp_avail <= 1'b1;
                exp_data  <= exp_q[0][15:0];
                exp_user  <= exp_q[0][16];
                exp_last  <= exp_q[0][17];
            end else begin
                exp_avail <= 1'b0;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && m_ready) |-> exp_avail)
        else abort_run("output pixel arrived while none was expected");

    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && m_ready && exp_avail) |-> (m_data == exp_data))
        else report_mismatch("m_data", 32'($sampled(exp_data)), 32'($sampled(m_data)));

    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && m_ready && exp_avail) |-> (m_user == exp_user))
        else report_mismatch("m_user", 32'($sampled(exp_user)), 32'($sampled(m_user)));

    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && m_ready && exp_avail) |-> (m_last == exp_last))
        else report_mismatch("m_last", 32'($sampled(exp_last)), 32'($sampled(m_last)));

    // Stalled beat keeps valid and payload
    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=>
            (m_valid && $stable(m_data) && $stable(m_user) && $stable(m_last)))
        else abort_run("output beat changed or was dropped while stalled");

    initial begin
        int waited;
        logic [1:0] mode;
        void'($urandom(32'h6fe9));
        aresetn = 1'b0;
        s_data  = '0;
        s_user  = '0;
        s_last  = 1'b0;
        s_valid = 1'b0;
        bp_en   = 1'b0;
        gap_en  = 1'b0;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        assert (m_valid == 1'b0) else report_mismatch("m_valid", 32'd0, 32'(m_valid));
        assert (s_ready == 1'b1) else report_mismatch("s_ready", 32'd1, 32'(s_ready));

        // Full resolution, then pass mode
        for (int i = 0; i < 8; i++) begin
            send_pixel(codec_pkg::rgb888_t'($urandom), 2'd0, (i % 4) == 3, i == 7);
        end
        for (int i = 0; i < 8; i++) begin
            send_pixel(codec_pkg::rgb888_t'($urandom), 2'd3, (i % 3) == 2, i == 7);
        end

        // Groups of 4
        for (int i = 0; i < 16; i++) begin
            send_pixel(codec_pkg::rgb888_t'($urandom), 2'd1, (i % 4) == 3, i == 15);
        end

        // Groups of 16, other modes on later pixels must be ignored
        for (int i = 0; i < 32; i++) begin
            mode = ((i % 16) == 0) ? 2'd2 : 2'(i % 4);
            send_pixel(codec_pkg::rgb888_t'($urandom), mode, (i % 16) == 15, i == 31);
        end

        // Frame end cuts groups short
        for (int i = 0; i < 3; i++) begin
            send_pixel(24'hf8fcf8, 2'd1, 1'b0, i == 2);
        end
        for (int i = 0; i < 4; i++) begin
            send_pixel(codec_pkg::rgb888_t'($urandom), 2'd1, i == 3, 1'b0);
        end
        for (int i = 0; i < 7; i++) begin
            send_pixel(24'hffffff, 2'd2, i == 6, i == 6);
        end
        send_pixel(codec_pkg::rgb888_t'($urandom), 2'd0, 1'b1, 1'b1);

        // Random stalls and gaps with random modes and flags
        bp_en  <= 1'b1;
        gap_en = 1'b1;
        for (int i = 0; i < 160; i++) begin
            send_pixel(codec_pkg::rgb888_t'($urandom), 2'($urandom),
                       ($urandom % 8) == 0, ($urandom % 20) == 0);
        end
        s_valid <= 1'b0;

        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(posedge aclk);
        end
        repeat (20) @(posedge aclk);
        if (exp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("ERROR at %0t: %0d expected pixels never arrived", $time, exp_q.size());
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

// ==== verilog.f ====
codec_pkg.sv
pixel_decode.sv
pixel_accumulate.sv
pixel_pack.sv
resolution_codec_top.sv
tb_resolution_codec.sv

// ==== Bender.yml ====
package:
  name: resolution_codec

sources:
  - files:
      - codec_pkg.sv
      - pixel_decode.sv
      - pixel_accumulate.sv
      - pixel_pack.sv
      - resolution_codec_top.sv
  - target: test
    files:
      - tb_resolution_codec.sv
